//--- build.f
+incdir+tests
common/song_pkg.sv
melody/melody_rom.sv
logic/note_sequencer.sv
logic/tone_generator.sv
logic/song_player_top.sv
tests/song_player_tb.sv

//--- common/song_pkg.sv
`default_nettype none

package song_pkg;

	// half-period counts fit in 10 bits, c is the longest
	localparam int HALF_WIDTH = 10;

	localparam int STEP_COUNT = 24;
	localparam int STEP_WIDTH = 5;

	// one beat per step
	localparam int BEAT_CYCLES = 8192;
	localparam int BEAT_WIDTH = 13;

	localparam int NOTE_COUNT = 13;

	localparam logic [STEP_WIDTH-1:0] STEP_LAST = STEP_WIDTH'(STEP_COUNT - 1);
	localparam logic [BEAT_WIDTH-1:0] BEAT_LAST = BEAT_WIDTH'(BEAT_CYCLES - 1);

	typedef enum logic [3:0]
	{
		c,
		c_sharp,
		d,
		d_sharp,
		e,
		f,
		f_sharp,
		g,
		g_sharp,
		a,
		a_sharp,
		b,
		rest
	} note_t;

	typedef enum logic [2:0]
	{
		epona,
		saria,
		storms,
		wind_requiem,
		lullaby
	} song_t;

	// indexed by note_t, speaker half-period in clock cycles minus one
	localparam logic [HALF_WIDTH-1:0] HALF_PERIOD [NOTE_COUNT] = '{
		10'd1023, 10'd965, 10'd911, 10'd861,
		10'd811, 10'd767, 10'd723, 10'd683,
		10'd645, 10'd607, 10'd573, 10'd541,
		10'd0 // rest
	};

	typedef struct packed
	{
		song_t                 song;
		logic [STEP_WIDTH-1:0] step;
	} melody_addr_t;

	typedef struct packed
	{
		note_t note;
		logic  start; // first cycle of a step
	} tone_cmd_t;

endpackage

`default_nettype wire

//--- logic/note_sequencer.sv
`default_nettype none

module note_sequencer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   play,
	input  song_pkg::song_t        song,
	input  song_pkg::note_t        note,
	output song_pkg::melody_addr_t melody_addr,
	output song_pkg::tone_cmd_t    tone_cmd,
	output logic                   busy,
	output logic                   done
);

	typedef enum logic
	{
		idle,
		playing
	} state_t;

	state_t                          state;
	song_pkg::song_t                 song_q;
	logic [song_pkg::BEAT_WIDTH-1:0] beat;
	logic [song_pkg::STEP_WIDTH-1:0] step;
	logic                            accept;
	logic                            beat_last;
	logic                            step_last;

	assign accept = state == idle && play;
	assign beat_last = beat == song_pkg::BEAT_LAST;
	assign step_last = step == song_pkg::STEP_LAST;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= idle;
			beat <= '0;
			step <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				idle:
				begin
					if (play)
					begin
						state <= playing;
						beat <= '0;
						step <= '0;
					end
				end
				playing:
				begin
					beat <= beat_last ? '0 : beat + 1'b1;
					if (beat_last)
					begin
						if (step_last)
						begin
							state <= idle; // song over
							done <= 1'b1;
						end
						else
						begin
							step <= step + 1'b1;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// song held for the whole play, input changes ignored
	always_ff @(posedge clk)
	begin
		if (accept)
			song_q <= song;
	end

	assign busy = state == playing;

	assign melody_addr.song = song_q;
	assign melody_addr.step = step;

	assign tone_cmd.note = note;
	assign tone_cmd.start = busy && beat == '0;

	a_done_not_busy: assert property (@(posedge clk) disable iff (rst)
		!(done && busy));

	a_step_in_range: assert property (@(posedge clk) disable iff (rst)
		busy |-> step <= song_pkg::STEP_LAST);

endmodule

`default_nettype wire

//--- logic/song_player_top.sv
`default_nettype none

module song_player_top (
	input  logic            clk,
	input  logic            rst,
	input  logic            play,
	input  song_pkg::song_t song,
	output logic            speaker,
	output logic            busy,
	output logic            done
);

	song_pkg::melody_addr_t melody_addr;
	song_pkg::note_t        note;
	song_pkg::tone_cmd_t    tone_cmd;

	note_sequencer note_sequencer_inst (
		.clk         (clk),
		.rst         (rst),
		.play        (play),
		.song        (song),
		.note        (note),
		.melody_addr (melody_addr),
		.tone_cmd    (tone_cmd),
		.busy        (busy),
		.done        (done)
	);

	melody_rom melody_rom_inst (
		.addr (melody_addr),
		.note (note)
	);

	tone_generator tone_generator_inst (
		.clk      (clk),
		.rst      (rst),
		.tone_cmd (tone_cmd),
		.active   (busy), // silent outside a song
		.speaker  (speaker)
	);

endmodule

`default_nettype wire

//--- logic/tone_generator.sv
`default_nettype none

module tone_generator (
	input  logic                clk,
	input  logic                rst,
	input  song_pkg::tone_cmd_t tone_cmd,
	input  logic                active,
	output logic                speaker
);

	song_pkg::note_t                 note_q;
	logic [song_pkg::HALF_WIDTH-1:0] half_q;
	logic [song_pkg::HALF_WIDTH-1:0] count;
	logic                            tone_q;
	logic                            mute;

	assign mute = !active || note_q == song_pkg::rest;

	always_ff @(posedge clk)
	begin
		if (tone_cmd.start)
			half_q <= song_pkg::HALF_PERIOD[tone_cmd.note];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			note_q <= song_pkg::rest;
			count <= '0;
			tone_q <= 1'b0;
		end
		else if (tone_cmd.start)
		begin
			// phase restarts on every step, even a repeated note
			note_q <= tone_cmd.note;
			count <= song_pkg::HALF_PERIOD[tone_cmd.note];
			tone_q <= 1'b0;
		end
		else if (mute)
		begin
			tone_q <= 1'b0;
		end
		else if (count == '0)
		begin
			count <= half_q;
			tone_q <= ~tone_q;
		end
		else
		begin
			count <= count - 1'b1;
		end
	end

	// covers the cycle where busy has just dropped
	assign speaker = tone_q && active;

	a_quiet_when_muted: assert property (@(posedge clk) disable iff (rst)
		(note_q == song_pkg::rest || !active) |-> !speaker);

endmodule

`default_nettype wire

//--- melody/melody_rom.sv
`default_nettype none

module melody_rom (
	input  song_pkg::melody_addr_t addr,
	output song_pkg::note_t        note
);

	always_comb
	begin
		note = song_pkg::rest;
		case (addr.song)
			song_pkg::epona:
			begin
				case (addr.step)
					5'd0:    note = song_pkg::d;
					5'd1:    note = song_pkg::b;
					5'd2:    note = song_pkg::a;
					5'd3:    note = song_pkg::a;
					5'd4:    note = song_pkg::a;
					5'd5:    note = song_pkg::a;
					5'd6:    note = song_pkg::d;
					5'd7:    note = song_pkg::b;
					5'd8:    note = song_pkg::a;
					5'd9:    note = song_pkg::a;
					5'd10:   note = song_pkg::a;
					5'd11:   note = song_pkg::a;
					5'd12:   note = song_pkg::d;
					5'd13:   note = song_pkg::b;
					5'd14:   note = song_pkg::a;
					5'd15:   note = song_pkg::a;
					5'd16:   note = song_pkg::b;
					5'd17:   note = song_pkg::b;
					5'd18:   note = song_pkg::a;
					5'd19:   note = song_pkg::a;
					5'd20:   note = song_pkg::a;
					5'd21:   note = song_pkg::a;
					5'd22:   note = song_pkg::rest;
					5'd23:   note = song_pkg::rest;
					default: note = song_pkg::rest;
				endcase
			end
			song_pkg::saria:
			begin
				case (addr.step)
					5'd0:    note = song_pkg::f;
					5'd1:    note = song_pkg::a;
					5'd2:    note = song_pkg::b;
					5'd3:    note = song_pkg::b;
					5'd4:    note = song_pkg::f;
					5'd5:    note = song_pkg::a;
					5'd6:    note = song_pkg::b;
					5'd7:    note = song_pkg::b;
					5'd8:    note = song_pkg::f;
					5'd9:    note = song_pkg::a;
					5'd10:   note = song_pkg::b;
					5'd11:   note = song_pkg::e;
					5'd12:   note = song_pkg::d;
					5'd13:   note = song_pkg::d;
					5'd14:   note = song_pkg::b;
					5'd15:   note = song_pkg::c;
					5'd16:   note = song_pkg::e;
					5'd17:   note = song_pkg::g;
					5'd18:   note = song_pkg::e;
					5'd19:   note = song_pkg::e;
					5'd20:   note = song_pkg::e;
					5'd21:   note = song_pkg::e;
					5'd22:   note = song_pkg::rest;
					5'd23:   note = song_pkg::rest;
					default: note = song_pkg::rest;
				endcase
			end
			song_pkg::storms:
			begin
				case (addr.step)
					5'd0:    note = song_pkg::d;
					5'd1:    note = song_pkg::f;
					5'd2:    note = song_pkg::d;
					5'd3:    note = song_pkg::d;
					5'd4:    note = song_pkg::d;
					5'd5:    note = song_pkg::d;
					5'd6:    note = song_pkg::d;
					5'd7:    note = song_pkg::f;
					5'd8:    note = song_pkg::d;
					5'd9:    note = song_pkg::d;
					5'd10:   note = song_pkg::d;
					5'd11:   note = song_pkg::d;
					5'd12:   note = song_pkg::e;
					5'd13:   note = song_pkg::e;
					5'd14:   note = song_pkg::e;
					5'd15:   note = song_pkg::f;
					5'd16:   note = song_pkg::e;
					5'd17:   note = song_pkg::f;
					5'd18:   note = song_pkg::e;
					5'd19:   note = song_pkg::c;
					5'd20:   note = song_pkg::a;
					5'd21:   note = song_pkg::a;
					5'd22:   note = song_pkg::a;
					5'd23:   note = song_pkg::a; // no closing rest, silence comes from idle
					default: note = song_pkg::rest;
				endcase
			end
			song_pkg::wind_requiem:
			begin
				case (addr.step)
					5'd0:    note = song_pkg::a;
					5'd1:    note = song_pkg::a;
					5'd2:    note = song_pkg::a;
					5'd3:    note = song_pkg::a;
					5'd4:    note = song_pkg::a;
					5'd5:    note = song_pkg::a;
					5'd6:    note = song_pkg::a;
					5'd7:    note = song_pkg::a;
					5'd8:    note = song_pkg::b;
					5'd9:    note = song_pkg::b;
					5'd10:   note = song_pkg::b;
					5'd11:   note = song_pkg::b;
					5'd12:   note = song_pkg::b;
					5'd13:   note = song_pkg::b;
					5'd14:   note = song_pkg::b;
					5'd15:   note = song_pkg::b;
					5'd16:   note = song_pkg::a;
					5'd17:   note = song_pkg::a;
					5'd18:   note = song_pkg::a;
					5'd19:   note = song_pkg::a;
					5'd20:   note = song_pkg::a;
					5'd21:   note = song_pkg::a;
					5'd22:   note = song_pkg::a;
					5'd23:   note = song_pkg::a;
					default: note = song_pkg::rest;
				endcase
			end
			song_pkg::lullaby:
			begin
				case (addr.step)
					5'd0:    note = song_pkg::b;
					5'd1:    note = song_pkg::b;
					5'd2:    note = song_pkg::b;
					5'd3:    note = song_pkg::b;
					5'd4:    note = song_pkg::d;
					5'd5:    note = song_pkg::d;
					5'd6:    note = song_pkg::a;
					5'd7:    note = song_pkg::a;
					5'd8:    note = song_pkg::a;
					5'd9:    note = song_pkg::a;
					5'd10:   note = song_pkg::g;
					5'd11:   note = song_pkg::a;
					5'd12:   note = song_pkg::b;
					5'd13:   note = song_pkg::b;
					5'd14:   note = song_pkg::b;
					5'd15:   note = song_pkg::b;
					5'd16:   note = song_pkg::d;
					5'd17:   note = song_pkg::d;
					5'd18:   note = song_pkg::a;
					5'd19:   note = song_pkg::a;
					5'd20:   note = song_pkg::a;
					5'd21:   note = song_pkg::a;
					5'd22:   note = song_pkg::a;
					5'd23:   note = song_pkg::a;
					default: note = song_pkg::rest;
				endcase
			end
			default: note = song_pkg::rest; // unused song codes
		endcase
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module song_player_tb -f build.f

output=$(./obj_dir/Vsong_player_tb)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
	exit 0
fi
exit 1

//--- tests/melody_model.svh
`ifndef MELODY_MODEL_SVH
`define MELODY_MODEL_SVH
`default_nettype none

// one character per step
function automatic string melody_text(input int song_idx);
	string text;
	case (song_idx)
		0: text = "dbaaaadbaaaadbaabbaaaa--"; // epona
		1: text = "fabbfabbfabeddbcegeeee--"; // saria
		2: text = "dfdddddfddddeeefefecaaaa"; // storms
		3: text = "aaaaaaaabbbbbbbbaaaaaaaa"; // wind requiem
		4: text = "bbbbddaaaagabbbbddaaaaaa"; // lullaby
		default: text = "------------------------";
	endcase
	return text;
endfunction

// upper case marks a sharp
function automatic int note_half_period(input byte ch);
	int hp;
	hp = 0;
	case (ch)
		"c": hp = 1023;
		"C": hp = 965;
		"d": hp = 911;
		"D": hp = 861;
		"e": hp = 811;
		"f": hp = 767;
		"F": hp = 723;
		"g": hp = 683;
		"G": hp = 645;
		"a": hp = 607;
		"A": hp = 573;
		"b": hp = 541;
		default: hp = 0; // rest
	endcase
	return hp;
endfunction

function automatic int model_half_period(input int song_idx, input int step);
	string text;
	text = melody_text(song_idx);
	return note_half_period(text[step]);
endfunction

`default_nettype wire
`endif

//--- tests/song_player_tb.sv
`include "melody_model.svh"
`default_nettype none

module song_player_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int SONG_CYCLES = song_pkg::STEP_COUNT * song_pkg::BEAT_CYCLES;
	localparam int IDLE_TIMEOUT = SONG_CYCLES + 100;

	logic            clk = 1'b0;
	logic            rst;
	logic            play;
	song_pkg::song_t song;
	logic            speaker;
	logic            busy;
	logic            done;

	int          errors;
	int          checks;
	logic [31:0] lcg_state;

	song_player_top song_player_top_inst (
		.clk     (clk),
		.rst     (rst),
		.play    (play),
		.song    (song),
		.speaker (speaker),
		.busy    (busy),
		.done    (done)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// outputs settle after the rising edge, so sample and drive here
	task automatic tick();
		@(negedge clk);
	endtask

	task automatic check(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual)
		begin
			errors++;
			$display("mismatch %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic wait_idle(input string name);
		int n;
		n = 0;
		while (busy && n < IDLE_TIMEOUT)
		begin
			tick();
			n++;
		end
		if (busy)
		begin
			errors++;
			$display("%s: timed out waiting for the player to go idle", name);
		end
	endtask

	// leaves the bench on the first cycle of step 0
	task automatic start_play(input int song_idx, input string name, output bit ok);
		int n;
		wait_idle(name);
		play = 1'b1;
		song = song_pkg::song_t'(3'(song_idx));
		tick();
		play = 1'b0;
		n = 0;
		while (!busy && n < 4)
		begin
			tick();
			n++;
		end
		ok = busy;
		if (!busy)
		begin
			errors++;
			$display("%s: timed out waiting for busy after a play pulse", name);
		end
		else
			check({name, " accept latency"}, 0, n);
	endtask

	// inject_step below zero means no extra play pulse
	task automatic play_song(input int song_idx, input string name, input int inject_step);
		int    hp;
		int    toggles;
		int    last;
		int    prev;
		int    loud;
		int    bad_ctrl;
		bit    ok;
		string step_name;
		start_play(song_idx, name, ok);
		if (!ok)
			return;
		bad_ctrl = 0;
		for (int step = 0; step < song_pkg::STEP_COUNT; step++)
		begin
			if (step > 0)
				tick();
			if (!busy || done)
				bad_ctrl++;
			hp = model_half_period(song_idx, step);
			step_name = $sformatf("%s song %0d step %0d", name, song_idx, step);
			toggles = 0;
			last = 0;
			prev = 0;
			loud = 0;
			for (int c = 1; c < song_pkg::BEAT_CYCLES; c++)
			begin
				tick();
				if (!busy || done)
					bad_ctrl++;
				if (hp == 0)
					loud += int'(speaker);
				else if (int'(speaker) != prev)
				begin
					if (toggles == 0)
						check({step_name, " first toggle"}, hp + 2, c);
					else
						check({step_name, " toggle interval"}, hp + 1, c - last);
					last = c;
					toggles++;
					prev = int'(speaker);
				end
				if (step == inject_step && c == 100)
				begin
					play = 1'b1;
					song = song_pkg::song_t'(3'((song_idx + 2) % 5));
				end
				if (step == inject_step && c == 101)
					play = 1'b0;
			end
			if (hp == 0)
				check({step_name, " rest high cycles"}, 0, loud);
			else
				check({step_name, " toggle count"},
					(song_pkg::BEAT_CYCLES - 1 - (hp + 2)) / (hp + 1) + 1, toggles);
		end
		check({name, " busy low or done high during play"}, 0, bad_ctrl);
		tick();
		check({name, " busy after last step"}, 0, int'(busy));
		check({name, " done after last step"}, 1, int'(done));
		check({name, " speaker after last step"}, 0, int'(speaker));
		tick();
		check({name, " done width"}, 0, int'(done));
		check({name, " busy idle"}, 0, int'(busy));
	endtask

	task automatic reset_state();
		int bad;
		bad = 0;
		repeat (100)
		begin
			tick();
			if (speaker || busy || done)
				bad++;
		end
		check("reset_state active outputs", 0, bad);
	endtask

	task automatic full_melodies();
		for (int s = 0; s < 5; s++)
			play_song(s, "full_melody", -1);
	endtask

	task automatic play_duration();
		int cycles;
		int early;
		bit ok;
		start_play(2, "play_duration", ok);
		if (!ok)
			return;
		cycles = 0;
		early = 0;
		while (busy && cycles < IDLE_TIMEOUT)
		begin
			if (done)
				early++;
			tick();
			cycles++;
		end
		if (busy)
		begin
			errors++;
			$display("play_duration: busy never fell");
			return;
		end
		check("play_duration busy cycles", SONG_CYCLES, cycles);
		check("play_duration done while busy", 0, early);
		check("play_duration done at fall", 1, int'(done));
		tick();
		check("play_duration done width", 0, int'(done));
	endtask

	task automatic play_while_busy();
		int bad;
		play_song(1, "play_while_busy", 10);
		bad = 0;
		repeat (3)
		begin
			tick();
			if (busy)
				bad++;
		end
		check("play_while_busy ignored play restarted", 0, bad);
	endtask

	task automatic random_sequence();
		int idx;
		for (int i = 0; i < 3; i++)
		begin
			lcg_state = lcg_next(lcg_state);
			idx = int'((lcg_state >> 16) % 32'd5);
			play_song(idx, "random_sequence", -1);
		end
	endtask

	initial
	begin
		rst = 1'b1;
		play = 1'b0;
		song = song_pkg::epona;
		errors = 0;
		checks = 0;
		lcg_state = 32'hb04f59a9;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		reset_state();
		full_melodies();
		play_duration();
		play_while_busy();
		random_sequence();

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
